// File: build.f
src/pss_pkg.sv
src/pss_peak_detector.sv
src/pss_nid_decision.sv
src/pss_peak_counters.sv
src/pss_detector.sv
bench/pss_detector_tb.sv

// File: Bender.yml
package:
  name: pss_detector

sources:
  - files:
      - src/pss_pkg.sv
      - src/pss_peak_detector.sv
      - src/pss_nid_decision.sv
      - src/pss_peak_counters.sv
      - src/pss_detector.sv

  - target: simulation
    files:
      - bench/pss_detector_tb.sv

// File: bench/pss_detector_patterns.txt
# mode req_nid noise_limit shift corr0 corr1 corr2 flags(b2 b1 b0) nid_valid nid
# one line per sample strobe, decimal except the flag bits
# window fill, large samples give no flag
0 0 20 1 500 16 16 000 0 0
0 0 20 1 16 600 16 000 0 0
0 0 20 1 16 16 700 000 0 0
0 0 20 1 16 16 16 000 0 0
0 0 20 1 16 16 16 000 0 0
0 0 20 1 16 16 16 000 0 0
0 0 20 1 16 16 16 000 0 0
0 0 20 1 16 16 16 000 0 0
0 0 20 1 16 16 16 000 0 0
0 0 20 1 16 16 16 000 0 0
0 0 20 1 16 16 16 000 0 0
# search mode, single and multiple peaks
0 0 20 1 40 16 16 001 1 0
0 0 20 1 16 45 16 010 1 1
0 0 20 1 16 16 50 100 1 2
0 0 20 1 60 60 16 011 0 0
0 0 20 1 100 100 100 111 0 0
0 0 20 1 16 16 16 000 0 0
0 0 20 1 16 16 16 000 0 0
0 0 20 1 16 16 16 000 0 0
0 0 20 1 16 16 16 000 0 0
0 0 20 1 16 16 16 000 0 0
0 0 20 1 16 16 16 000 0 0
0 0 20 1 16 16 16 000 0 0
0 0 20 1 16 16 16 000 0 0
# thresholds, shift 0 to 7
0 0 40 0 40 16 16 000 0 0
0 0 10 1 16 32 33 100 1 2
0 0 10 2 76 16 16 000 0 0
0 0 10 2 16 73 16 010 1 1
0 0 10 3 208 16 145 100 1 2
0 0 10 4 16 401 544 010 1 1
0 0 10 5 1601 16 16 001 1 0
0 0 10 6 16 4672 6401 100 1 2
0 0 10 7 31745 65535 16 001 1 0
0 0 20 0 16 16 16 000 0 0
0 0 20 0 16 16 16 000 0 0
0 0 20 0 16 16 16 000 0 0
0 0 20 0 16 16 16 000 0 0
0 0 20 0 16 16 16 000 0 0
0 0 20 0 16 16 16 000 0 0
0 0 20 0 16 16 16 000 0 0
0 0 20 0 16 16 16 000 0 0
# find mode
1 1 20 1 16 40 16 010 1 1
1 1 20 1 40 16 16 001 0 0
1 1 20 1 16 16 40 100 0 0
1 1 20 1 40 40 16 011 0 0
1 2 20 1 16 16 50 100 1 2
1 2 20 1 16 16 16 000 0 0
# pause, then a decision on the untouched windows
2 2 20 1 1000 1000 1000 000 0 0
2 2 20 1 40 50 60 000 0 0
2 2 20 0 500 16 16 000 0 0
2 2 20 1 16 900 16 000 0 0
3 2 20 1 2000 16 16 000 0 0
0 2 20 1 45 44 16 001 1 0
0 2 20 1 16 16 47 100 1 2
1 0 20 1 51 16 16 001 1 0
1 0 20 0 30 23 28 110 0 0
1 0 20 0 29 16 16 001 1 0
1 0 30 0 31 30 16 001 1 0
0 0 20 2 116 16 101 100 1 2
0 0 20 2 16 89 16 010 1 1
0 0 20 2 165 125 16 011 0 0
0 0 20 2 16 16 16 000 0 0

// File: bench/pss_detector_tb.sv
`timescale 1ns/1ps
`default_nettype none

module pss_detector_tb;

    import pss_pkg::*;

    localparam int CLK_PERIOD = 40;
    localparam int RESET_CYCLES = 16;
    localparam string PATTERN_FILE = "bench/pss_detector_patterns.txt";

    logic clk_i = 1'b0;
    logic reset_ni;

    logic [MAG_W-1:0] corr0_i;
    logic [MAG_W-1:0] corr1_i;
    logic [MAG_W-1:0] corr2_i;
    logic corr_valid_i;
    logic [MAG_W-1:0] noise_limit_i;
    logic [SHIFT_W-1:0] detection_shift_i;
    logic [MODE_W-1:0] mode_i;
    logic [NID_W-1:0] requested_nid_i;

    logic [NID_W-1:0] nid_o;
    logic nid_valid_o;
    logic [NUM_BRANCH-1:0] peak_flags_o;
    logic [COUNT_W-1:0] peak_count0_o;
    logic [COUNT_W-1:0] peak_count1_o;
    logic [COUNT_W-1:0] peak_count2_o;

    // one entry per pattern line
    int pat_mode [$];
    int pat_req [$];
    int pat_noise [$];
    int pat_shift [$];
    int pat_c0 [$];
    int pat_c1 [$];
    int pat_c2 [$];
    int pat_flags [$];
    int pat_valid [$];
    int pat_nid [$];
    int num_lines;

    // expected results of strobes still in the pipeline
    // each result packs {valid, nid}
    logic [NUM_BRANCH-1:0] exp_flags_q [$];
    logic [NID_W:0] exp_result_q [$];
    int exp_count [NUM_BRANCH];

    logic strobe_d1 = 1'b0;
    logic strobe_d2 = 1'b0;
    logic checking = 1'b0;
    int cycle_cnt = 0;
    int cycle_limit = 0;
    logic [31:0] rand_state;

    pss_detector UUT (
        .clk_i             (clk_i),
        .reset_ni          (reset_ni),
        .corr0_i           (corr0_i),
        .corr1_i           (corr1_i),
        .corr2_i           (corr2_i),
        .corr_valid_i      (corr_valid_i),
        .noise_limit_i     (noise_limit_i),
        .detection_shift_i (detection_shift_i),
        .mode_i            (mode_i),
        .requested_nid_i   (requested_nid_i),
        .nid_o             (nid_o),
        .nid_valid_o       (nid_valid_o),
        .peak_flags_o      (peak_flags_o),
        .peak_count0_o     (peak_count0_o),
        .peak_count1_o     (peak_count1_o),
        .peak_count2_o     (peak_count2_o)
    );

    always #(CLK_PERIOD/2) clk_i = ~clk_i;

    // ------------------------------------------------------------------------
    // helpers
    // ------------------------------------------------------------------------

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Something failed");
        $fatal(1, "run stopped");
    endtask

    task automatic compare_value(input logic [31:0] actual, input logic [31:0] expected,
                                 input string what);
        if (actual !== expected) begin
            abort_run($sformatf("mismatch at %0d ns: %s, expected %0d, got %0d",
                                $time, what, expected, actual));
        end
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] state);
        logic [31:0] x;
        x = state;
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        return x;
    endfunction

    task automatic load_patterns();
        int fd;
        int fields;
        string line;
        int f_mode, f_req, f_noise, f_shift;
        int f_c0, f_c1, f_c2;
        int f_flags, f_valid, f_nid;
        fd = $fopen(PATTERN_FILE, "r");
        if (fd == 0) begin
            abort_run("could not open the pattern file");
        end
        while ($fgets(line, fd) > 0) begin
            if (line.len() < 2 || line.getc(0) == "#") begin
                continue;
            end
            fields = $sscanf(line, "%d %d %d %d %d %d %d %b %d %d", f_mode, f_req,
                             f_noise, f_shift, f_c0, f_c1, f_c2, f_flags, f_valid, f_nid);
            if (fields != 10) begin
                abort_run("the pattern file has a line with missing fields");
            end
            pat_mode.push_back(f_mode);
            pat_req.push_back(f_req);
            pat_noise.push_back(f_noise);
            pat_shift.push_back(f_shift);
            pat_c0.push_back(f_c0);
            pat_c1.push_back(f_c1);
            pat_c2.push_back(f_c2);
            pat_flags.push_back(f_flags);
            pat_valid.push_back(f_valid);
            pat_nid.push_back(f_nid);
        end
        $fclose(fd);
        num_lines = pat_mode.size();
    endtask

    task automatic idle_cycle();
        @(posedge clk_i);
        corr_valid_i <= 1'b0;
    endtask

    // earlier flags must reach the decision under the old mode first
    task automatic change_mode(input int mode, input int req);
        repeat (2) idle_cycle();
        @(posedge clk_i);
        mode_i <= MODE_W'(mode);
        requested_nid_i <= NID_W'(req);
        corr_valid_i <= 1'b0;
        // branch_en follows one cycle later, then one more to settle
        repeat (2) @(posedge clk_i);
    endtask

    task automatic drive_strobe(input int idx);
        logic [NID_W:0] result;
        @(posedge clk_i);
        corr0_i <= MAG_W'(pat_c0[idx]);
        corr1_i <= MAG_W'(pat_c1[idx]);
        corr2_i <= MAG_W'(pat_c2[idx]);
        noise_limit_i <= MAG_W'(pat_noise[idx]);
        detection_shift_i <= SHIFT_W'(pat_shift[idx]);
        mode_i <= MODE_W'(pat_mode[idx]);
        requested_nid_i <= NID_W'(pat_req[idx]);
        corr_valid_i <= 1'b1;
        result = {pat_valid[idx] != 0, NID_W'(pat_nid[idx])};
        exp_flags_q.push_back(NUM_BRANCH'(pat_flags[idx]));
        exp_result_q.push_back(result);
        for (int b = 0; b < NUM_BRANCH; b++) begin
            if (((pat_flags[idx] >> b) & 1) != 0) begin
                exp_count[b]++;
            end
        end
    endtask

    // ------------------------------------------------------------------------
    // outputs are sampled on the falling edge
    // ------------------------------------------------------------------------

    always @(posedge clk_i) begin
        strobe_d1 <= corr_valid_i;
        strobe_d2 <= strobe_d1;
    end

    always @(negedge clk_i) begin : check_outputs
        logic [NUM_BRANCH-1:0] flags;
        logic [NID_W:0] result;
        if (checking) begin
            if (strobe_d1) begin
                if (exp_flags_q.size() == 0) begin
                    abort_run("peak flags arrived with no expected value queued");
                end
                flags = exp_flags_q.pop_front();
                compare_value(peak_flags_o, flags, "peak flags");
            end else begin
                compare_value(peak_flags_o, 0, "peak flags in an idle cycle");
            end
            if (strobe_d2) begin
                if (exp_result_q.size() == 0) begin
                    abort_run("a decision arrived with no expected value queued");
                end
                result = exp_result_q.pop_front();
                compare_value(nid_valid_o, result[NID_W], "nid_valid");
                if (result[NID_W]) begin
                    compare_value(nid_o, result[NID_W-1:0], "nid");
                end
            end else begin
                compare_value(nid_valid_o, 0, "nid_valid in an idle cycle");
            end
        end
    end

    always @(posedge clk_i) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= cycle_limit) begin
            abort_run($sformatf("the run timed out after %0d cycles", cycle_cnt));
        end
    end

    // ------------------------------------------------------------------------
    // main sequence
    // ------------------------------------------------------------------------

    initial begin
        int cur_mode;
        int cur_req;
        int gap;
        reset_ni = 1'b0;
        corr0_i = '0;
        corr1_i = '0;
        corr2_i = '0;
        corr_valid_i = 1'b0;
        noise_limit_i = '0;
        detection_shift_i = '0;
        mode_i = MODE_PAUSE;
        requested_nid_i = '0;
        for (int b = 0; b < NUM_BRANCH; b++) begin
            exp_count[b] = 0;
        end
        rand_state = 32'd45;

        load_patterns();
        cycle_limit = 4 * num_lines + 100;

        repeat (RESET_CYCLES) @(posedge clk_i);
        reset_ni <= 1'b1;
        checking <= 1'b1;

        cur_mode = MODE_PAUSE;
        cur_req = 0;
        for (int i = 0; i < num_lines; i++) begin
            if (pat_mode[i] != cur_mode || pat_req[i] != cur_req) begin
                change_mode(pat_mode[i], pat_req[i]);
                cur_mode = pat_mode[i];
                cur_req = pat_req[i];
            end
            drive_strobe(i);
            rand_state = xorshift32(rand_state);
            gap = rand_state % 4;
            repeat (gap) idle_cycle();
        end

        // let the last strobe reach the counters
        repeat (4) idle_cycle();
        @(negedge clk_i);
        if (exp_flags_q.size() != 0 || exp_result_q.size() != 0) begin
            abort_run("some expected results were never checked");
        end
        compare_value(peak_count0_o, exp_count[0], "peak count of branch 0");
        compare_value(peak_count1_o, exp_count[1], "peak count of branch 1");
        compare_value(peak_count2_o, exp_count[2], "peak count of branch 2");

        $display("Everything OK");
        $finish;
    end

endmodule

`default_nettype wire

// File: src/pss_detector.sv
`timescale 1ns/1ps
`default_nettype none

module pss_detector (
    input  wire                             clk_i,
    input  wire                             reset_ni,

    // correlator magnitudes, one per N_id_2
    input  wire  [pss_pkg::MAG_W-1:0]       corr0_i,
    input  wire  [pss_pkg::MAG_W-1:0]       corr1_i,
    input  wire  [pss_pkg::MAG_W-1:0]       corr2_i,
    input  wire                             corr_valid_i,

    input  wire  [pss_pkg::MAG_W-1:0]       noise_limit_i,
    input  wire  [pss_pkg::SHIFT_W-1:0]     detection_shift_i,
    input  wire  [pss_pkg::MODE_W-1:0]      mode_i,
    input  wire  [pss_pkg::NID_W-1:0]       requested_nid_i,

    output logic [pss_pkg::NID_W-1:0]       nid_o,
    output logic                            nid_valid_o,
    output logic [pss_pkg::NUM_BRANCH-1:0]  peak_flags_o,
    output logic [pss_pkg::COUNT_W-1:0]     peak_count0_o,
    output logic [pss_pkg::COUNT_W-1:0]     peak_count1_o,
    output logic [pss_pkg::COUNT_W-1:0]     peak_count2_o
);

    import pss_pkg::*;

    logic branch_en;
    logic [NUM_BRANCH-1:0] peaks;

    // ------------------------------------------------------------------------
    // per-branch peak detectors
    // ------------------------------------------------------------------------

    pss_peak_detector peak_detector_0_i (
        .clk_i             (clk_i),
        .reset_ni          (reset_ni),
        .sample_i          (corr0_i),
        .valid_i           (corr_valid_i),
        .enable_i          (branch_en),
        .noise_limit_i     (noise_limit_i),
        .detection_shift_i (detection_shift_i),
        .peak_o            (peaks[0])
    );

    pss_peak_detector peak_detector_1_i (
        .clk_i             (clk_i),
        .reset_ni          (reset_ni),
        .sample_i          (corr1_i),
        .valid_i           (corr_valid_i),
        .enable_i          (branch_en),
        .noise_limit_i     (noise_limit_i),
        .detection_shift_i (detection_shift_i),
        .peak_o            (peaks[1])
    );

    pss_peak_detector peak_detector_2_i (
        .clk_i             (clk_i),
        .reset_ni          (reset_ni),
        .sample_i          (corr2_i),
        .valid_i           (corr_valid_i),
        .enable_i          (branch_en),
        .noise_limit_i     (noise_limit_i),
        .detection_shift_i (detection_shift_i),
        .peak_o            (peaks[2])
    );

    // ------------------------------------------------------------------------
    // N_id_2 decision and peak statistics
    // ------------------------------------------------------------------------

    pss_nid_decision nid_decision_i (
        .clk_i           (clk_i),
        .reset_ni        (reset_ni),
        .mode_i          (mode_i),
        .requested_nid_i (requested_nid_i),
        .peaks_i         (peaks),
        .branch_en_o     (branch_en),
        .nid_o           (nid_o),
        .nid_valid_o     (nid_valid_o)
    );

    pss_peak_counters peak_counters_i (
        .clk_i    (clk_i),
        .reset_ni (reset_ni),
        .peaks_i  (peaks),
        .count0_o (peak_count0_o),
        .count1_o (peak_count1_o),
        .count2_o (peak_count2_o)
    );

    assign peak_flags_o = peaks;

endmodule

`default_nettype wire

// File: src/pss_peak_counters.sv
`timescale 1ns/1ps
`default_nettype none

module pss_peak_counters (
    input  wire                             clk_i,
    input  wire                             reset_ni,
    input  wire  [pss_pkg::NUM_BRANCH-1:0]  peaks_i,
    output logic [pss_pkg::COUNT_W-1:0]     count0_o,
    output logic [pss_pkg::COUNT_W-1:0]     count1_o,
    output logic [pss_pkg::COUNT_W-1:0]     count2_o
);

    import pss_pkg::*;

    // ------------------------------------------------------------------------
    // one counter per branch
    // ------------------------------------------------------------------------

    logic [COUNT_W-1:0] count_q [NUM_BRANCH];

    // wraps at 2**COUNT_W, only reset clears it
    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            for (int i = 0; i < NUM_BRANCH; i++) begin
                count_q[i] <= '0;
            end
        end else begin
            for (int i = 0; i < NUM_BRANCH; i++) begin
                if (peaks_i[i]) begin
                    count_q[i] <= count_q[i] + 1'b1;
                end
            end
        end
    end

    assign count0_o = count_q[0];
    assign count1_o = count_q[1];
    assign count2_o = count_q[2];

endmodule

`default_nettype wire

// File: src/pss_nid_decision.sv
`timescale 1ns/1ps
`default_nettype none

module pss_nid_decision (
    input  wire                             clk_i,
    input  wire                             reset_ni,
    input  wire  [pss_pkg::MODE_W-1:0]      mode_i,
    input  wire  [pss_pkg::NID_W-1:0]       requested_nid_i,
    input  wire  [pss_pkg::NUM_BRANCH-1:0]  peaks_i,
    output logic                            branch_en_o,
    output logic [pss_pkg::NID_W-1:0]       nid_o,
    output logic                            nid_valid_o
);

    import pss_pkg::*;

    logic one_hot;
    logic [NID_W-1:0] hot_idx;
    logic accept;
    logic mode_active;

    // ------------------------------------------------------------------------
    // exactly one branch must flag
    // ------------------------------------------------------------------------

    always_comb begin
        one_hot = 1'b1;
        hot_idx = '0;
        case (peaks_i)
            NUM_BRANCH'(1): hot_idx = NID_W'(0);
            NUM_BRANCH'(2): hot_idx = NID_W'(1);
            NUM_BRANCH'(4): hot_idx = NID_W'(2);
            default: one_hot = 1'b0;
        endcase
    end

    // ------------------------------------------------------------------------
    // mode FSM
    // ------------------------------------------------------------------------

    // find mode compares indices, so a requested value of 3 never matches
    always_comb begin
        case (mode_i)
            MODE_SEARCH: accept = one_hot;
            MODE_FIND: accept = one_hot && (hot_idx == requested_nid_i);
            default: accept = 1'b0;
        endcase
    end

    assign mode_active = (mode_i == MODE_SEARCH) || (mode_i == MODE_FIND);

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            branch_en_o <= 1'b0;
            nid_valid_o <= 1'b0;
            nid_o <= '0;
        end else begin
            branch_en_o <= mode_active;
            nid_valid_o <= accept;
            // nid holds until the next accepted peak
            if (accept) begin
                nid_o <= hot_idx;
            end
        end
    end

endmodule

`default_nettype wire

// File: src/pss_peak_detector.sv
`timescale 1ns/1ps
`default_nettype none

module pss_peak_detector (
    input  wire                          clk_i,
    input  wire                          reset_ni,
    input  wire  [pss_pkg::MAG_W-1:0]    sample_i,
    input  wire                          valid_i,
    input  wire                          enable_i,
    input  wire  [pss_pkg::MAG_W-1:0]    noise_limit_i,
    input  wire  [pss_pkg::SHIFT_W-1:0]  detection_shift_i,
    output logic                         peak_o
);

    import pss_pkg::*;

    // ------------------------------------------------------------------------
    // window state
    // ------------------------------------------------------------------------

    // history[0] holds the newest sample, the last entry the oldest
    logic [MAG_W-1:0] history [WINDOW_LEN];

    logic [MAG_W+WINDOW_LOG-1:0] win_sum;
    logic [WINDOW_LOG:0] fill_cnt;
    logic filled;

    // ------------------------------------------------------------------------
    // threshold and peak rule
    // ------------------------------------------------------------------------

    logic [MAG_W-1:0] win_avg;
    logic [MAG_W+(1<<SHIFT_W)-2:0] threshold;
    logic [MAG_W+(1<<SHIFT_W)-2:0] sample_wide;
    logic accept;
    logic is_peak;

    assign accept = valid_i && enable_i;
    assign filled = (fill_cnt == (WINDOW_LOG+1)'(WINDOW_LEN));

    // dividing by WINDOW_LEN is a plain slice of the sum
    assign win_avg = win_sum[MAG_W+WINDOW_LOG-1:WINDOW_LOG];

    // widened first so that a shift of up to 7 loses no bits
    assign threshold = (MAG_W+(1<<SHIFT_W)-1)'(win_avg) << detection_shift_i;
    assign sample_wide = (MAG_W+(1<<SHIFT_W)-1)'(sample_i);

    // both comparisons are strict, equality is not a peak
    assign is_peak = filled
                  && (sample_i > noise_limit_i)
                  && (sample_wide > threshold);

    // ------------------------------------------------------------------------
    // registered peak flag
    // ------------------------------------------------------------------------

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            peak_o <= 1'b0;
        end else begin
            peak_o <= accept && is_peak;
        end
    end

    // ------------------------------------------------------------------------
    // fill counter and running sum
    // ------------------------------------------------------------------------

    // while filling, the oldest entry is not yet part of the sum
    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            fill_cnt <= '0;
            win_sum <= '0;
        end else if (accept) begin
            if (filled) begin
                win_sum <= win_sum
                         + (MAG_W+WINDOW_LOG)'(sample_i)
                         - (MAG_W+WINDOW_LOG)'(history[WINDOW_LEN-1]);
            end else begin
                fill_cnt <= fill_cnt + 1'b1;
                win_sum <= win_sum + (MAG_W+WINDOW_LOG)'(sample_i);
            end
        end
    end

    // sample history
    always_ff @(posedge clk_i) begin
        if (accept) begin
            history[0] <= sample_i;
            for (int i = 1; i < WINDOW_LEN; i++) begin
                history[i] <= history[i-1];
            end
        end
    end

endmodule

`default_nettype wire

// File: src/pss_pkg.sv
`default_nettype none

package pss_pkg;

    // ------------------------------------------------------------------------
    // sample and control widths
    // ------------------------------------------------------------------------

    // correlator magnitude and noise limit
    localparam int MAG_W = 16;

    // detection shift, scales the window average by 2**shift
    localparam int SHIFT_W = 3;

    // ------------------------------------------------------------------------
    // moving window
    // ------------------------------------------------------------------------

    localparam int WINDOW_LEN = 8;
    localparam int WINDOW_LOG = 3;

    // ------------------------------------------------------------------------
    // N_id_2 hypotheses and mode
    // ------------------------------------------------------------------------

    localparam int NUM_BRANCH = 3;
    localparam int NID_W = 2;

    localparam int MODE_W = 2;

    // code 3 is not listed and acts as pause
    localparam logic [MODE_W-1:0] MODE_SEARCH = 2'd0;
    localparam logic [MODE_W-1:0] MODE_FIND = 2'd1;
    localparam logic [MODE_W-1:0] MODE_PAUSE = 2'd2;

    // per-branch peak counters
    localparam int COUNT_W = 32;

endpackage

`default_nettype wire
